/* Makefile */
# Verilator flow for the uProc debug and memory-bus corner.
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tbUProc
RTL_TOP   ?= uProc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* jtagPort.sv */
// JTAG instruction and data registers on top of the TAP state.
// Sequences SRAM writes and reads, holds the control word, relays pins to SPI.
`timescale 1ns/100ps

module jtagPort #(
    parameter int addrWidth = 16,
    parameter int dataWidth = 16
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 tck,
    input  logic                 tckRise,
    input  logic                 tdi,
    input  uprocPkg::tapState_t  state,
    output logic                 tdo,
    output logic [addrWidth-1:0] sramAddr,
    output logic [dataWidth-1:0] sramWrData,
    output logic                 sramWr,
    output logic                 sramEn,
    input  logic [dataWidth-1:0] sramRdData,
    output logic                 enPaused,
    output logic                 enSPIRelay,
    output logic                 spiSck,
    output logic                 spiSdo,
    input  logic                 spiSdi,
    output logic                 spiScs
);

    import uprocPkg::*;

    jtagInstr_t instr;
    logic [2:0] irShift;
    jtagWord_t  dataReg;
    logic       bypassReg;
    logic       stepped;
    logic       tckPrev;
    logic       tdoReg;
    logic       tdoNext;
    logic       updateEntry;
    logic       irEntry;

    // The data register is one JTAG word wide.
    if (dataWidth != $bits(jtagWord_t) || addrWidth != $bits(jtagWord_t)) begin : gWidthCheck
        $error("jtagPort expects 16-bit address and data");
    end

    // Unused codes fall back to BYPASS.
    function automatic jtagInstr_t decodeInstr(input logic [2:0] code);
        case (code)
            3'd1:    decodeInstr = IDCODE;
            3'd2:    decodeInstr = ADDR;
            3'd3:    decodeInstr = WRITE;
            3'd4:    decodeInstr = READ;
            3'd5:    decodeInstr = CTRL;
            default: decodeInstr = BYPASS;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Step tracking and TDO timing.
    ////////////////////////////////////////////////////////////

    // High in the first cycle of each new TAP state.
    assign updateEntry = stepped && (state == TAP_UPDATE_DR);
    assign irEntry     = stepped && (state == TAP_UPDATE_IR);

    // TDO moves after a falling TCK.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stepped <= 1'b0;
            tckPrev <= 1'b0;
            tdoReg  <= 1'b0;
        end else begin
            stepped <= tckRise;
            tckPrev <= tck;
            if (tckPrev && !tck) begin
                tdoReg <= tdoNext;
            end
        end
    end

    // Bit presented while shifting.
    always_comb begin
        if (state == TAP_SHIFT_IR) begin
            tdoNext = irShift[0];
        end else if (state == TAP_SHIFT_DR && instr == BYPASS) begin
            tdoNext = bypassReg;
        end else if (state == TAP_SHIFT_DR) begin
            tdoNext = dataReg.raw[0];
        end else begin
            tdoNext = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction register.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            irShift <= 3'b001;
            instr   <= IDCODE;
        end else if (state == TAP_RESET) begin
            instr <= IDCODE;
        end else if (irEntry) begin
            instr <= decodeInstr(irShift);
        end else if (tckRise && state == TAP_CAPTURE_IR) begin
            irShift <= 3'b001;
        end else if (tckRise && state == TAP_SHIFT_IR) begin
            // LSB first.
            irShift <= {tdi, irShift[2:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Data and bypass registers.
    ////////////////////////////////////////////////////////////

    // Capture on the rise that leaves Capture-DR.
    always_ff @(posedge clk) begin
        if (tckRise && state == TAP_CAPTURE_DR) begin
            bypassReg <= 1'b0;
            case (instr)
                IDCODE: dataReg.raw <= ID_CODE;
                ADDR:   dataReg.raw <= sramAddr;
                READ:   dataReg.raw <= sramRdData;
                CTRL: begin
                    dataReg.ctrl.reserved   <= '0;
                    dataReg.ctrl.enSPIRelay <= enSPIRelay;
                    dataReg.ctrl.enPaused   <= enPaused;
                end
                default: ;
            endcase
        end else if (tckRise && state == TAP_SHIFT_DR) begin
            bypassReg   <= tdi;
            dataReg.raw <= {tdi, dataReg.raw[15:1]};
        end
    end

    // Address pointer and control word, acted on at Update-DR entry.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sramAddr   <= '0;
            enPaused   <= 1'b0;
            enSPIRelay <= 1'b0;
        end else if (updateEntry) begin
            case (instr)
                ADDR:        sramAddr <= dataReg.raw;
                // Post-increment after each access.
                WRITE, READ: sramAddr <= sramAddr + addrWidth'(1);
                CTRL: begin
                    enPaused   <= dataReg.ctrl.enPaused;
                    enSPIRelay <= dataReg.ctrl.enSPIRelay;
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // SRAM request and SPI relay.
    ////////////////////////////////////////////////////////////

    // Write strobe for one cycle; read enable across Capture-DR.
    assign sramWr     = updateEntry && (instr == WRITE);
    assign sramEn     = sramWr || (instr == READ && state == TAP_CAPTURE_DR);
    assign sramWrData = dataReg.raw;

    // Host talks to the EEPROM through the JTAG pins.
    assign spiSck = enSPIRelay & tck;
    assign spiSdo = enSPIRelay & tdi;
    assign spiScs = ~enSPIRelay;
    assign tdo    = enSPIRelay ? spiSdi : tdoReg;

    // A write is always enabled and never repeats on the next cycle.
    assert property (@(posedge clk) disable iff (!rstN)
        sramWr |-> sramEn ##1 !sramWr)
        else $error("jtagPort write strobe malformed");

endmodule

/* jtagTap.sv */
// IEEE 1149.1 TAP controller, stepped by the synchronized TCK rise pulse.
// The current state feeds the JTAG port registers.
`timescale 1ns/100ps

module jtagTap (
    input  logic                clk,
    input  logic                rstN,
    input  logic                tckRise,
    input  logic                tms,
    output uprocPkg::tapState_t state
);

    import uprocPkg::*;

    tapState_t nextState;

    ////////////////////////////////////////////////////////////
    // Next state.
    ////////////////////////////////////////////////////////////

    // Standard sixteen-state graph.
    // TMS high five times lands in reset from anywhere.
    always_comb begin
        case (state)
            TAP_RESET:      nextState = tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       nextState = tms ? TAP_SELECT_DR : TAP_IDLE;
            // Data register column.
            TAP_SELECT_DR:  nextState = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: nextState = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   nextState = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   nextState = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   nextState = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   nextState = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  nextState = tms ? TAP_SELECT_DR : TAP_IDLE;
            // Instruction register column.
            TAP_SELECT_IR:  nextState = tms ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: nextState = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   nextState = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   nextState = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   nextState = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   nextState = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  nextState = tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        nextState = TAP_RESET;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State register.
    ////////////////////////////////////////////////////////////

    // Moves only on the cycle that carries tckRise.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= TAP_RESET;
        end else if (tckRise) begin
            state <= nextState;
        end
    end

    // State holds a known legal code out of reset.
    assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(state) && (state inside {[TAP_EXIT2_DR:TAP_RESET]}))
        else $error("jtagTap left the legal state set");

endmodule

/* memoryController.sv */
// Chooses the SRAM bus owner among boot, JTAG and processor.
// Splits the selected address into RAM and the mapped page. Purely combinational.
`timescale 1ns/100ps

module memoryController #(
    parameter int addrWidth = 16
) (
    input  logic [addrWidth-1:0] procAddr,
    input  logic                 procWr,
    input  logic                 procEn,
    input  logic [addrWidth-1:0] jtagAddr,
    input  logic                 jtagWr,
    input  logic                 jtagEn,
    input  logic [addrWidth-1:0] bootAddr,
    input  logic                 bootWr,
    input  logic                 bootEn,
    input  logic                 isPaused,
    input  logic                 isBooted,
    output logic [addrWidth-1:0] busAddr,
    output logic                 busWr,
    output logic                 busRamEn,
    output logic                 busMapEn
);

    import uprocPkg::*;

    logic busEn;
    logic isMapPage;

    always_comb begin
        // Boot first, then a paused JTAG host, else the processor.
        if (!isBooted) begin
            busAddr = bootAddr;
            busWr   = bootWr;
            busEn   = bootEn;
        end else if (isPaused) begin
            busAddr = jtagAddr;
            busWr   = jtagWr;
            busEn   = jtagEn;
        end else begin
            busAddr = procAddr;
            busWr   = procWr;
            busEn   = procEn;
        end

        // Top byte picks the region.
        isMapPage = (busAddr[addrWidth-1 -: 8] == MAP_PAGE);
        busRamEn  = busEn && !isMapPage;
        busMapEn  = busEn && isMapPage;

        assert (!(busRamEn && busMapEn))
            else $error("memoryController enabled RAM and mapped region together");
    end

endmodule

/* pinSynch.sv */
// Brings the asynchronous JTAG pins into the clk domain.
// Lanes are {TCK, TDI, TMS}; also emits a one-cycle pulse on each TCK rise.
`timescale 1ns/100ps

module pinSynch #(
    parameter int numStages = 2
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic [2:0] pinIn,
    output logic [2:0] pinOut,
    output logic       tckRise
);

    logic tckPrev;

    // One flop chain per pin lane.
    for (genvar lane = 0; lane < 3; lane++) begin : gLane
        logic [numStages-1:0] chain;

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                chain <= '0;
            end else begin
                chain <= {chain[numStages-2:0], pinIn[lane]};
            end
        end

        assign pinOut[lane] = chain[numStages-1];
    end

    // Edge detect on the synchronized TCK lane.
    // Pulse is registered, so it trails pinOut by one cycle.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tckPrev <= 1'b0;
            tckRise <= 1'b0;
        end else begin
            tckPrev <= pinOut[2];
            tckRise <= pinOut[2] & ~tckPrev;
        end
    end

endmodule

/* tbUProc.sv */
// Testbench for uProc. Bit-bangs the JTAG pins, models the SRAM and
// checks the bus against a reference model on every clk cycle.
// Built and run through the Makefile; the exit status gives the result.
`timescale 1ns/100ps

module tbUProc;

    import uprocPkg::*;

    localparam int addrWidth = 16;
    localparam int dataWidth = 16;
    localparam int numWords  = 4;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 jtagTCK;
    logic                 jtagTDI;
    logic                 jtagTMS;
    logic                 jtagTDO;
    logic                 spiSCK;
    logic                 spiSDO;
    logic                 spiSCS;
    logic                 spiSDI;
    logic [addrWidth-1:0] sramAddr;
    logic                 sramWr;
    logic                 sramEn;
    logic [dataWidth-1:0] sramWrData;
    logic                 sramOe;
    logic [dataWidth-1:0] sramRdData;
    logic [addrWidth-1:0] procAddr;
    logic                 procWr;
    logic                 procEn;
    logic [addrWidth-1:0] bootAddr;
    logic                 bootWr;
    logic                 bootEn;
    logic                 isBooted;
    logic                 busMapEn;

    // SRAM contents and write count.
    logic [dataWidth-1:0] mem [0:65535];
    int unsigned          writeCount;
    // Bus check enable and the pause state the host last set.
    logic                 busCheckOn;
    logic                 expPaused;

    uProc #(
        .addrWidth(addrWidth),
        .dataWidth(dataWidth),
        .numStages(2)
    ) dut (
        .clk(clk), .rstN(rstN),
        .jtagTCK(jtagTCK), .jtagTDI(jtagTDI), .jtagTMS(jtagTMS), .jtagTDO(jtagTDO),
        .spiSCK(spiSCK), .spiSDO(spiSDO), .spiSCS(spiSCS), .spiSDI(spiSDI),
        .sramAddr(sramAddr), .sramWr(sramWr), .sramEn(sramEn),
        .sramWrData(sramWrData), .sramOe(sramOe), .sramRdData(sramRdData),
        .procAddr(procAddr), .procWr(procWr), .procEn(procEn),
        .bootAddr(bootAddr), .bootWr(bootWr), .bootEn(bootEn),
        .isBooted(isBooted), .busMapEn(busMapEn)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // SRAM model.
    ////////////////////////////////////////////////////////////

    // Fill pattern from the whole address.
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]] = {i[7:0], i[15:8]} ^ 16'hC3A5;
        end
    end

    // Asynchronous read, write on the clk edge.
    assign sramRdData = mem[sramAddr];

    always @(posedge clk) begin
        if (!rstN) begin
            writeCount <= 0;
        end else if (sramEn && sramWr) begin
            mem[sramAddr] <= sramWrData;
            writeCount    <= writeCount + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checks.
    ////////////////////////////////////////////////////////////

    // Expected {addr, wr, ramEn, mapEn} from the owner rule and page decode.
    function automatic logic [18:0] expectedBus(
        input logic        booted,
        input logic        paused,
        input logic [15:0] pAddr,
        input logic        pWr,
        input logic        pEn,
        input logic [15:0] jAddr,
        input logic        jWr,
        input logic        jEn,
        input logic [15:0] bAddr,
        input logic        bWr,
        input logic        bEn
    );
        logic [1:0]  owner;
        logic [15:0] addr;
        logic        wr;
        logic        en;
        logic        mapped;
        // Owner 0 is boot, 1 is JTAG, 2 is the processor.
        owner = !booted ? 2'd0 : (paused ? 2'd1 : 2'd2);
        case (owner)
            2'd0:    {addr, wr, en} = {bAddr, bWr, bEn};
            2'd1:    {addr, wr, en} = {jAddr, jWr, jEn};
            default: {addr, wr, en} = {pAddr, pWr, pEn};
        endcase
        mapped = (addr[15:8] == MAP_PAGE);
        return {addr, wr, en && !mapped, en && mapped};
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out waiting for %s.", what);
        $display("TB FAILED");
        $fatal(1, "wait timeout");
    endtask

    // Compares the bus mid-cycle when all inputs are settled.
    always @(negedge clk) begin
        logic [18:0] expBus;
        if (rstN && busCheckOn) begin
            expBus = expectedBus(isBooted, expPaused, procAddr, procWr, procEn,
                dut.jtagAddr, dut.jtagWr, dut.jtagEn, bootAddr, bootWr, bootEn);
            checkEq(32'(sramAddr), 32'(expBus[18:3]), "SRAM address");
            checkEq(32'(sramWr), 32'(expBus[2]), "SRAM write");
            checkEq(32'(sramOe), 32'(expBus[2]), "SRAM output enable");
            checkEq(32'(sramEn), 32'(expBus[1]), "SRAM enable");
            checkEq(32'(busMapEn), 32'(expBus[0]), "mapped-region enable");
        end
    end

    ////////////////////////////////////////////////////////////
    // JTAG bit-bang.
    ////////////////////////////////////////////////////////////

    // One TCK period of 8 clk. Starts and ends 5 ns after a rising edge.
    task automatic tckBit(input logic tms, input logic tdi, output logic tdoBit);
        jtagTMS = tms;
        jtagTDI = tdi;
        jtagTCK = 1'b0;
        repeat (4) @(posedge clk);
        #5 jtagTCK = 1'b1;
        repeat (4) @(posedge clk);
        // TDO only moves after a falling TCK.
        #5 tdoBit = jtagTDO;
    endtask

    task automatic tapReset();
        logic unused;
        repeat (5) tckBit(1'b1, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
    endtask

    // Idle to Shift-IR, three bits LSB first, Update-IR, back to Idle.
    task automatic shiftIR(input logic [2:0] code);
        logic unused;
        tckBit(1'b1, 1'b0, unused);
        tckBit(1'b1, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
        for (int i = 0; i < 3; i++) begin
            tckBit(i == 2, code[i], unused);
        end
        tckBit(1'b1, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
    endtask

    // Full 16-bit DR scan from Idle back to Idle.
    task automatic shiftDR(input logic [15:0] dataIn, output logic [15:0] dataOut);
        logic unused;
        tckBit(1'b1, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
        for (int i = 0; i < 16; i++) begin
            tckBit(i == 15, dataIn[i], dataOut[i]);
        end
        tckBit(1'b1, 1'b0, unused);
        tckBit(1'b0, 1'b0, unused);
    endtask

    // Control word load. Bus checks pause across the ownership change.
    task automatic writeCtrl(input logic spiRelay, input logic paused);
        jtagWord_t  word;
        logic [15:0] unused;
        word.raw             = '0;
        word.ctrl.enSPIRelay = spiRelay;
        word.ctrl.enPaused   = paused;
        shiftIR(CTRL);
        busCheckOn = 1'b0;
        shiftDR(word.raw, unused);
        expPaused  = paused;
        busCheckOn = 1'b1;
    endtask

    // Random processor and boot requests for a number of cycles.
    task automatic driveRandom(input int cycles, input logic mapped);
        for (int n = 0; n < cycles; n++) begin
            procAddr = 16'($urandom);
            if (mapped) begin
                procAddr[15:8] = MAP_PAGE;
            end
            procWr   = 1'($urandom);
            procEn   = mapped | 1'($urandom);
            bootAddr = 16'($urandom);
            bootWr   = 1'($urandom);
            bootEn   = 1'($urandom);
            if (isBooted && !expPaused && procEn) begin
                #1;
                checkEq(32'(busMapEn), 32'(procAddr[15:8] == MAP_PAGE), "processor map enable");
                checkEq(32'(sramEn), 32'(procAddr[15:8] != MAP_PAGE), "processor RAM enable");
            end
            @(posedge clk);
            #5;
        end
        procEn = 1'b0;
        bootEn = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////////////////////////

    initial begin
        logic [15:0]       got;
        logic [15:0]       pattern;
        logic [15:0]       base;
        logic [15:0]       oldWord;
        logic [15:0]       words[$];
        logic              bit0;
        int unsigned       countBefore;
        int                n;

        void'($urandom(32'he883_9867));
        rstN = 1'b0;
        {jtagTCK, jtagTDI, jtagTMS, spiSDI} = 4'b0;
        {procAddr, procWr, procEn} = '0;
        {bootAddr, bootWr, bootEn} = '0;
        isBooted   = 1'b0;
        busCheckOn = 1'b1;
        expPaused  = 1'b0;
        repeat (2) @(posedge clk);
        #5 rstN = 1'b1;

        // ID code after TAP reset, then one-bit bypass delay.
        tapReset();
        shiftDR(16'h0000, got);
        checkEq(32'(got), 32'(ID_CODE), "IDCODE scan");
        shiftIR(BYPASS);
        pattern = 16'($urandom);
        shiftDR(pattern, got);
        checkEq(32'(got), 32'({pattern[14:0], 1'b0}), "BYPASS scan");

        // Boot owns the bus before boot.
        driveRandom(20, 1'b0);

        // Paused JTAG writes and reads back a block of words.
        isBooted = 1'b1;
        writeCtrl(1'b0, 1'b1);
        base = 16'($urandom) & 16'h7FF0;
        shiftIR(ADDR);
        shiftDR(base, got);
        shiftIR(WRITE);
        for (int i = 0; i < numWords; i++) begin
            words.push_back(16'($urandom));
            countBefore = writeCount;
            shiftDR(words[i], got);
            checkEq(writeCount, countBefore + 1, "JTAG write strobe count");
            checkEq(32'(mem[base + 16'(i)]), 32'(words[i]), "SRAM word after JTAG write");
        end
        shiftIR(ADDR);
        shiftDR(base, got);
        shiftIR(READ);
        for (int i = 0; i < numWords; i++) begin
            shiftDR(16'h0000, got);
            checkEq(32'(got), 32'(words[i]), "JTAG read data");
        end

        // Boot still wins while paused.
        isBooted = 1'b0;
        driveRandom(20, 1'b0);
        isBooted = 1'b1;

        // Processor owns the bus; mapped page and RAM split.
        writeCtrl(1'b0, 1'b0);
        driveRandom(20, 1'b1);
        driveRandom(20, 1'b0);

        // Unpaused JTAG writes never reach the SRAM.
        procAddr = 16'($urandom) & 16'h7FFF;
        procWr   = 1'b0;
        procEn   = 1'b1;
        base     = 16'($urandom) & 16'h7FFF;
        oldWord  = mem[base];
        countBefore = writeCount;
        shiftIR(ADDR);
        shiftDR(base, got);
        shiftIR(WRITE);
        shiftDR(~oldWord, got);
        checkEq(32'(mem[base]), 32'(oldWord), "SRAM word after unpaused write");
        checkEq(writeCount, countBefore, "SRAM write count after unpaused write");
        procEn = 1'b0;

        // SPI relay.
        checkEq(32'(spiSCS), 32'(1'b1), "SPI chip select before relay");
        writeCtrl(1'b1, 1'b0);
        for (n = 0; n < 10 && spiSCS !== 1'b0; n++) begin
            @(posedge clk);
            #5;
        end
        if (spiSCS !== 1'b0) begin
            failTimeout("spiSCS to go low");
        end
        // TMS stays low, so the TAP idles while TCK toggles.
        repeat (4) begin
            bit0    = ~jtagTDI;
            jtagTDI = bit0;
            jtagTCK = bit0;
            spiSDI  = ~bit0;
            for (n = 0; n < 10 && (spiSDO !== bit0 || spiSCK !== bit0 ||
                    jtagTDO !== ~bit0); n++) begin
                @(posedge clk);
                #5;
            end
            if (spiSDO !== bit0 || spiSCK !== bit0 || jtagTDO !== ~bit0) begin
                failTimeout("spiSCK, spiSDO and jtagTDO to follow the relayed pins");
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* uProc.sv */
// Top of the debug and memory-bus corner of the microprocessor.
// JTAG pins pass a synchronizer to the TAP and JTAG port; the memory
// controller drives the SRAM pins. The SRAM data pad tristate is external.
`timescale 1ns/100ps

module uProc #(
    parameter int addrWidth = 16,
    parameter int dataWidth = 16,
    parameter int numStages = 2
) (
    input  logic                 clk,
    input  logic                 rstN,
    // JTAG pins.
    input  logic                 jtagTCK,
    input  logic                 jtagTDI,
    input  logic                 jtagTMS,
    output logic                 jtagTDO,
    // SPI EEPROM pins.
    output logic                 spiSCK,
    output logic                 spiSDO,
    output logic                 spiSCS,
    input  logic                 spiSDI,
    // SRAM pins.
    output logic [addrWidth-1:0] sramAddr,
    output logic                 sramWr,
    output logic                 sramEn,
    output logic [dataWidth-1:0] sramWrData,
    output logic                 sramOe,
    input  logic [dataWidth-1:0] sramRdData,
    // Processor and boot requests.
    input  logic [addrWidth-1:0] procAddr,
    input  logic                 procWr,
    input  logic                 procEn,
    input  logic [addrWidth-1:0] bootAddr,
    input  logic                 bootWr,
    input  logic                 bootEn,
    input  logic                 isBooted,
    output logic                 busMapEn
);

    import uprocPkg::*;

    ////////////////////////////////////////////////////////////
    // Wires.
    ////////////////////////////////////////////////////////////

    // Lanes are {TCK, TDI, TMS}.
    logic [2:0]           synchIn;
    logic [2:0]           synchOut;
    logic                 tckRise;
    tapState_t            tapState;
    logic [addrWidth-1:0] jtagAddr;
    logic                 jtagWr;
    logic                 jtagEn;
    logic                 jtagPaused;

    assign synchIn = {jtagTCK, jtagTDI, jtagTMS};

    ////////////////////////////////////////////////////////////
    // Instances.
    ////////////////////////////////////////////////////////////

    pinSynch #(
        .numStages(numStages)
    ) uPinSynch (
        .clk     (clk),
        .rstN    (rstN),
        .pinIn   (synchIn),
        .pinOut  (synchOut),
        .tckRise (tckRise)
    );

    jtagTap uJtagTap (
        .clk     (clk),
        .rstN    (rstN),
        .tckRise (tckRise),
        .tms     (synchOut[0]),
        .state   (tapState)
    );

    // Debug access port.
    jtagPort #(
        .addrWidth(addrWidth),
        .dataWidth(dataWidth)
    ) uJtagPort (
        .clk        (clk),
        .rstN       (rstN),
        .tck        (synchOut[2]),
        .tckRise    (tckRise),
        .tdi        (synchOut[1]),
        .state      (tapState),
        .tdo        (jtagTDO),
        .sramAddr   (jtagAddr),
        .sramWrData (sramWrData),
        .sramWr     (jtagWr),
        .sramEn     (jtagEn),
        .sramRdData (sramRdData),
        .enPaused   (jtagPaused),
        .enSPIRelay (),
        .spiSck     (spiSCK),
        .spiSdo     (spiSDO),
        .spiSdi     (spiSDI),
        .spiScs     (spiSCS)
    );

    // Bus owner select and address decode.
    memoryController #(
        .addrWidth(addrWidth)
    ) uMemoryController (
        .procAddr (procAddr),
        .procWr   (procWr),
        .procEn   (procEn),
        .jtagAddr (jtagAddr),
        .jtagWr   (jtagWr),
        .jtagEn   (jtagEn),
        .bootAddr (bootAddr),
        .bootWr   (bootWr),
        .bootEn   (bootEn),
        .isPaused (jtagPaused),
        .isBooted (isBooted),
        .busAddr  (sramAddr),
        .busWr    (sramWr),
        .busRamEn (sramEn),
        .busMapEn (busMapEn)
    );

    // Drive the data pads whenever the bus writes.
    assign sramOe = sramWr;

endmodule

/* uprocPkg.sv */
// Shared definitions for the debug port and memory bus of the 16-bit processor.
// Imported by the TAP, the JTAG port, the memory controller and the testbench.
package uprocPkg;

    // TAP controller states, usual 4-bit encoding.
    typedef enum logic [3:0] {
        TAP_EXIT2_DR   = 4'h0,
        TAP_EXIT1_DR   = 4'h1,
        TAP_SHIFT_DR   = 4'h2,
        TAP_PAUSE_DR   = 4'h3,
        TAP_SELECT_IR  = 4'h4,
        TAP_UPDATE_DR  = 4'h5,
        TAP_CAPTURE_DR = 4'h6,
        TAP_SELECT_DR  = 4'h7,
        TAP_EXIT2_IR   = 4'h8,
        TAP_EXIT1_IR   = 4'h9,
        TAP_SHIFT_IR   = 4'hA,
        TAP_PAUSE_IR   = 4'hB,
        TAP_IDLE       = 4'hC,
        TAP_UPDATE_IR  = 4'hD,
        TAP_CAPTURE_IR = 4'hE,
        TAP_RESET      = 4'hF
    } tapState_t;

    // JTAG instructions. Codes 0 and 6 behave as BYPASS.
    typedef enum logic [2:0] {
        IDCODE = 3'd1,
        ADDR   = 3'd2,
        WRITE  = 3'd3,
        READ   = 3'd4,
        CTRL   = 3'd5,
        BYPASS = 3'd7
    } jtagInstr_t;

    // One data register word, seen as SRAM data or as the control word.
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [13:0] reserved;
            logic        enSPIRelay;
            logic        enPaused;
        } ctrl;
    } jtagWord_t;

    // Identification value returned under IDCODE.
    localparam logic [15:0] ID_CODE = 16'h5A11;

    // Top address byte of the mapped region.
    localparam logic [7:0] MAP_PAGE = 8'hFF;

endpackage

/* vlog.f */
uprocPkg.sv
pinSynch.sv
jtagTap.sv
jtagPort.sv
memoryController.sv
uProc.sv
tbUProc.sv
